/* include/analog_cfg.svh */
`ifndef ANALOG_CFG_SVH
`define ANALOG_CFG_SVH

//////////////////////////////
// channel layout
//////////////////////////////

// acquisition and generation channels
`define ANALOG_CHN 2
// raw ADC word, two low bits unused
`define ADC_IN_W 16
// signed sample width on both paths
`define SMP_W 14

//////////////////////////////
// calibration and bus
//////////////////////////////

// gain width and its fraction bits
`define CAL_MUL_W 16
`define CAL_FRAC 13
// gain of 1.0 in Q2.13
`define CAL_UNITY 8192
// free running timestamp
`define CTS_W 64
// register bus word address and data
`define BUS_AW 4
`define BUS_DW 32

`endif

/* design/analog_pkg.sv */
`include "analog_cfg.svh"

package analog_pkg;

  // signed sample on scope and generator side
  typedef logic signed [`SMP_W-1:0] sample_t;

  // gain in fixed point
  typedef logic signed [`CAL_MUL_W-1:0] cal_mul_t;

  // offset in sample units
  typedef logic signed [`SMP_W-1:0] cal_sum_t;

  // one calibration stage
  typedef struct packed {
    cal_mul_t mul;
    cal_sum_t sum;
  } cal_cfg_t;

  // everything one channel needs from the registers
  typedef struct packed {
    cal_cfg_t adc_cal;
    cal_cfg_t dac_cal;
    // digital loopback enable
    logic     loop;
  } chan_cfg_t;

  // captured scope samples and the timestamp of capture
  typedef struct packed {
    sample_t [`ANALOG_CHN-1:0] osc;
    logic    [`CTS_W-1:0]      cts;
  } snap_t;

endpackage

/* design/regbus_pkg.sv */
`include "analog_cfg.svh"

package regbus_pkg;

  // word address map
  typedef enum logic [`BUS_AW-1:0] {
    ADDR_MUX       = 4'd0,
    ADDR_ADC_MUL0  = 4'd1,
    ADDR_ADC_SUM0  = 4'd2,
    ADDR_ADC_MUL1  = 4'd3,
    ADDR_ADC_SUM1  = 4'd4,
    ADDR_DAC_MUL0  = 4'd5,
    ADDR_DAC_SUM0  = 4'd6,
    ADDR_DAC_MUL1  = 4'd7,
    ADDR_DAC_SUM1  = 4'd8,
    ADDR_SNAP_TRIG = 4'd9,
    ADDR_SNAP_OSC0 = 4'd10,
    ADDR_SNAP_OSC1 = 4'd11,
    ADDR_CTS_LO    = 4'd12,
    ADDR_CTS_HI    = 4'd13
  } reg_addr_e;

  // single cycle strobes from the master
  typedef struct packed {
    logic                wen;
    logic                ren;
    logic [`BUS_AW-1:0]  addr;
    logic [`BUS_DW-1:0]  wdata;
  } bus_req_t;

  // ack one cycle after the strobe
  typedef struct packed {
    logic                ack;
    logic [`BUS_DW-1:0]  rdata;
  } bus_rsp_t;

endpackage

/* design/reg_decode.sv */
`timescale 1ns/1ps
`include "analog_cfg.svh"

module reg_decode (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  regbus_pkg::bus_req_t  bus_req_i,
  output regbus_pkg::bus_rsp_t  bus_rsp_o,
  input  analog_pkg::snap_t     snap_i,
  output analog_pkg::chan_cfg_t chan_cfg_o [`ANALOG_CHN],
  output logic                  snap_stb_o
);

  regbus_pkg::reg_addr_e addr;
  logic [`BUS_DW-1:0]    rd_dat;

  // gains read back zero extended
  function automatic logic [`BUS_DW-1:0] zext_mul(input analog_pkg::cal_mul_t mul);
    return {{(`BUS_DW-`CAL_MUL_W){1'b0}}, mul};
  endfunction

  // offsets and samples read back sign extended
  function automatic logic [`BUS_DW-1:0] sext_smp(input analog_pkg::sample_t smp);
    return {{(`BUS_DW-`SMP_W){smp[`SMP_W-1]}}, smp};
  endfunction

  // unmapped codes fall to default
  assign addr = regbus_pkg::reg_addr_e'(bus_req_i.addr);

  //////////////////////////////
  // read multiplexer
  //////////////////////////////

  always_comb begin
    rd_dat = '0;
    case (addr)
      regbus_pkg::ADDR_MUX: begin
        for (int i = 0; i < `ANALOG_CHN; i++) begin
          rd_dat[i] = chan_cfg_o[i].loop;
        end
      end
      regbus_pkg::ADDR_ADC_MUL0:  rd_dat = zext_mul(chan_cfg_o[0].adc_cal.mul);
      regbus_pkg::ADDR_ADC_SUM0:  rd_dat = sext_smp(chan_cfg_o[0].adc_cal.sum);
      regbus_pkg::ADDR_ADC_MUL1:  rd_dat = zext_mul(chan_cfg_o[1].adc_cal.mul);
      regbus_pkg::ADDR_ADC_SUM1:  rd_dat = sext_smp(chan_cfg_o[1].adc_cal.sum);
      regbus_pkg::ADDR_DAC_MUL0:  rd_dat = zext_mul(chan_cfg_o[0].dac_cal.mul);
      regbus_pkg::ADDR_DAC_SUM0:  rd_dat = sext_smp(chan_cfg_o[0].dac_cal.sum);
      regbus_pkg::ADDR_DAC_MUL1:  rd_dat = zext_mul(chan_cfg_o[1].dac_cal.mul);
      regbus_pkg::ADDR_DAC_SUM1:  rd_dat = sext_smp(chan_cfg_o[1].dac_cal.sum);
      regbus_pkg::ADDR_SNAP_OSC0: rd_dat = sext_smp(snap_i.osc[0]);
      regbus_pkg::ADDR_SNAP_OSC1: rd_dat = sext_smp(snap_i.osc[1]);
      regbus_pkg::ADDR_CTS_LO:    rd_dat = snap_i.cts[`BUS_DW-1:0];
      regbus_pkg::ADDR_CTS_HI:    rd_dat = snap_i.cts[`CTS_W-1:`BUS_DW];
      // trigger is write only
      default:                    rd_dat = '0;
    endcase
  end

  //////////////////////////////
  // registers and handshake
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus_rsp_o  <= '0;
      snap_stb_o <= 1'b0;
      for (int i = 0; i < `ANALOG_CHN; i++) begin
        chan_cfg_o[i].adc_cal.mul <= analog_pkg::cal_mul_t'(`CAL_UNITY);
        chan_cfg_o[i].adc_cal.sum <= '0;
        chan_cfg_o[i].dac_cal.mul <= analog_pkg::cal_mul_t'(`CAL_UNITY);
        chan_cfg_o[i].dac_cal.sum <= '0;
        chan_cfg_o[i].loop        <= 1'b0;
      end
    end else begin
      // every access answered one cycle later
      bus_rsp_o.ack   <= bus_req_i.wen | bus_req_i.ren;
      bus_rsp_o.rdata <= bus_req_i.ren ? rd_dat : '0;
      snap_stb_o      <= bus_req_i.wen && (addr == regbus_pkg::ADDR_SNAP_TRIG);
      if (bus_req_i.wen) begin
        case (addr)
          regbus_pkg::ADDR_MUX: begin
            for (int i = 0; i < `ANALOG_CHN; i++) begin
              chan_cfg_o[i].loop <= bus_req_i.wdata[i];
            end
          end
          regbus_pkg::ADDR_ADC_MUL0: chan_cfg_o[0].adc_cal.mul <= bus_req_i.wdata[`CAL_MUL_W-1:0];
          regbus_pkg::ADDR_ADC_SUM0: chan_cfg_o[0].adc_cal.sum <= bus_req_i.wdata[`SMP_W-1:0];
          regbus_pkg::ADDR_ADC_MUL1: chan_cfg_o[1].adc_cal.mul <= bus_req_i.wdata[`CAL_MUL_W-1:0];
          regbus_pkg::ADDR_ADC_SUM1: chan_cfg_o[1].adc_cal.sum <= bus_req_i.wdata[`SMP_W-1:0];
          regbus_pkg::ADDR_DAC_MUL0: chan_cfg_o[0].dac_cal.mul <= bus_req_i.wdata[`CAL_MUL_W-1:0];
          regbus_pkg::ADDR_DAC_SUM0: chan_cfg_o[0].dac_cal.sum <= bus_req_i.wdata[`SMP_W-1:0];
          regbus_pkg::ADDR_DAC_MUL1: chan_cfg_o[1].dac_cal.mul <= bus_req_i.wdata[`CAL_MUL_W-1:0];
          regbus_pkg::ADDR_DAC_SUM1: chan_cfg_o[1].dac_cal.sum <= bus_req_i.wdata[`SMP_W-1:0];
          // read only and unmapped words ignored
          default: ;
        endcase
      end
    end
  end

endmodule

/* design/cal_linear.sv */
`timescale 1ns/1ps
`include "analog_cfg.svh"

module cal_linear (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  input  analog_pkg::cal_cfg_t cal_i,
  input  analog_pkg::sample_t  smp_i,
  output analog_pkg::sample_t  smp_o
);

  // full product width
  localparam int PW = `SMP_W + `CAL_MUL_W;

  logic signed [PW-1:0] prod_q;
  logic signed [PW-1:0] sum_c;
  logic                 ovf_c;

  // drop fraction bits and add offset
  always_comb begin
    sum_c = (prod_q >>> `CAL_FRAC) + cal_i.sum;
  end

  // overflow when bits above the sample msb are not all equal
  assign ovf_c = !((&sum_c[PW-1:`SMP_W-1]) || (~|sum_c[PW-1:`SMP_W-1]));

  //////////////////////////////
  // two stage pipeline
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
      smp_o  <= '0;
    end else begin
      // stage 1 multiply
      prod_q <= smp_i * cal_i.mul;
      // stage 2 clip to the rail given by the sign
      if (ovf_c) begin
        smp_o <= sum_c[PW-1] ? {1'b1, {(`SMP_W-1){1'b0}}}
                             : {1'b0, {(`SMP_W-1){1'b1}}};
      end else begin
        smp_o <= sum_c[`SMP_W-1:0];
      end
    end
  end

endmodule

/* design/channel_path.sv */
`timescale 1ns/1ps
`include "analog_cfg.svh"

module channel_path (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  logic [`ADC_IN_W-1:0]  adc_raw_i,
  input  analog_pkg::sample_t   gen_i,
  input  analog_pkg::chan_cfg_t cfg_i,
  output analog_pkg::sample_t   osc_o,
  output logic [`SMP_W-1:0]     dac_o
);

  analog_pkg::sample_t adc_q;
  analog_pkg::sample_t dac_smp;
  analog_pkg::sample_t osc_sel;

  //////////////////////////////
  // ADC side
  //////////////////////////////

  // capture register
  // negative slope offset binary to signed
  // two low bits dropped
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_q <= '0;
    end else begin
      adc_q <= {adc_raw_i[`ADC_IN_W-1], ~adc_raw_i[`ADC_IN_W-2:`ADC_IN_W-`SMP_W]};
    end
  end

  // loopback takes the calibrated generator sample
  assign osc_sel = cfg_i.loop ? dac_smp : adc_q;

  cal_linear adc_cal_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .cal_i   (cfg_i.adc_cal),
    .smp_i   (osc_sel),
    .smp_o   (osc_o)
  );

  //////////////////////////////
  // DAC side
  //////////////////////////////

  cal_linear dac_cal_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .cal_i   (cfg_i.dac_cal),
    .smp_i   (gen_i),
    .smp_o   (dac_smp)
  );

  // output code register
  // signed back to negative slope offset binary
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_o <= '0;
    end else begin
      dac_o <= {dac_smp[`SMP_W-1], ~dac_smp[`SMP_W-2:0]};
    end
  end

endmodule

/* design/scope_snapshot.sv */
`timescale 1ns/1ps
`include "analog_cfg.svh"

module scope_snapshot (
  input  logic                adc_clk,
  input  logic                top_rst,
  input  analog_pkg::sample_t osc_i [`ANALOG_CHN],
  input  logic                snap_stb_i,
  output analog_pkg::snap_t   snap_o
);

  logic [`CTS_W-1:0] cts_q;
  analog_pkg::snap_t live;
  analog_pkg::snap_t snap_q;

  // current samples with current timestamp
  always_comb begin
    for (int i = 0; i < `ANALOG_CHN; i++) begin
      live.osc[i] = osc_i[i];
    end
    live.cts = cts_q;
  end

  // timestamp counter and capture
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cts_q  <= '0;
      snap_q <= '0;
    end else begin
      // zero in first cycle after reset
      cts_q <= cts_q + 1'b1;
      if (snap_stb_i) begin
        snap_q <= live;
      end
    end
  end

  // during the strobe show what is being captured
  // so a read alongside the trigger ack sees the new values
  assign snap_o = snap_stb_i ? live : snap_q;

endmodule

/* design/analog_top.sv */
`timescale 1ns/1ps
`include "analog_cfg.svh"

module analog_top (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  input  logic [`ANALOG_CHN-1:0][`ADC_IN_W-1:0] adc_dat_i,
  input  analog_pkg::sample_t                   gen_dat_i [`ANALOG_CHN],
  output logic [`ANALOG_CHN-1:0][`SMP_W-1:0]    dac_dat_o,
  input  regbus_pkg::bus_req_t                  bus_req_i,
  output regbus_pkg::bus_rsp_t                  bus_rsp_o
);

  analog_pkg::chan_cfg_t chan_cfg [`ANALOG_CHN];
  analog_pkg::sample_t   osc      [`ANALOG_CHN];
  analog_pkg::snap_t     snap;
  logic                  snap_stb;

  // registers
  reg_decode reg_decode_i (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .bus_req_i  (bus_req_i),
    .bus_rsp_o  (bus_rsp_o),
    .snap_i     (snap),
    .chan_cfg_o (chan_cfg),
    .snap_stb_o (snap_stb)
  );

  // per channel data path
  for (genvar i = 0; i < `ANALOG_CHN; i++) begin : g_chn
    channel_path channel_path_i (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .adc_raw_i (adc_dat_i[i]),
      .gen_i     (gen_dat_i[i]),
      .cfg_i     (chan_cfg[i]),
      .osc_o     (osc[i]),
      .dac_o     (dac_dat_o[i])
    );
  end

  // timestamp and software capture
  scope_snapshot scope_snapshot_i (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .osc_i      (osc),
    .snap_stb_i (snap_stb),
    .snap_o     (snap)
  );

endmodule

/* verification/analog_top_tb.sv */
`timescale 1ns/1ps
`include "analog_cfg.svh"

module analog_top_tb;

  // cycle budget of all tests, doubled for the watchdog
  localparam int BUDGET = 40 + 60 + 120 + 80 + 60 + 50;
  localparam int SMAX = (1 << (`SMP_W - 1)) - 1;
  localparam int SMIN = -(1 << (`SMP_W - 1));
  // snapshot spacing for the timestamp test
  localparam int GAP = 25;

  logic                                  adc_clk;
  logic                                  top_rst;
  logic [`ANALOG_CHN-1:0][`ADC_IN_W-1:0] adc_dat;
  analog_pkg::sample_t                   gen_dat [`ANALOG_CHN];
  logic [`ANALOG_CHN-1:0][`SMP_W-1:0]    dac_dat;
  regbus_pkg::bus_req_t                  bus_req;
  regbus_pkg::bus_rsp_t                  bus_rsp;
  integer seed = 32'h3c2b0556;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  // last calibration written per channel
  int adc_mul [`ANALOG_CHN];
  int adc_sum [`ANALOG_CHN];
  int dac_mul [`ANALOG_CHN];
  int dac_sum [`ANALOG_CHN];

  analog_top analog_top_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .gen_dat_i (gen_dat),
    .dac_dat_o (dac_dat),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  initial begin
    #(BUDGET * 2 * 4);
    $display("watchdog expired, the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // gain in Q2.13, offset, clip to sample range
  function automatic int cal_model(int x, int mul, int sum);
    longint p;
    p = (longint'(x) * mul) >>> `CAL_FRAC;
    p = p + sum;
    if (p > SMAX) p = SMAX;
    if (p < SMIN) p = SMIN;
    return int'(p);
  endfunction

  // keep top bit, invert the rest, low two bits dropped
  function automatic int adc_model(logic [`ADC_IN_W-1:0] raw);
    analog_pkg::sample_t s;
    s = raw[`ADC_IN_W-1:`ADC_IN_W-`SMP_W];
    s[`SMP_W-2:0] = ~s[`SMP_W-2:0];
    return s;
  endfunction

  function automatic logic [`SMP_W-1:0] dac_model(int smp);
    logic [`SMP_W-1:0] c;
    c = smp[`SMP_W-1:0];
    c[`SMP_W-2:0] = ~c[`SMP_W-2:0];
    return c;
  endfunction

  //////////////////////////////
  // bus and check helpers
  //////////////////////////////

  task automatic check_eq(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // one strobe, ack expected at the next falling edge
  task automatic bus_cycle(logic wr, logic [`BUS_AW-1:0] addr, logic [`BUS_DW-1:0] wdata,
                           output logic [`BUS_DW-1:0] rdata);
    bus_req.wen = wr;
    bus_req.ren = !wr;
    bus_req.addr = addr;
    bus_req.wdata = wdata;
    @(negedge adc_clk);
    bus_req = '0;
    rdata = bus_rsp.rdata;
    if (!bus_rsp.ack) begin
      errors++;
      $display("bus access to address %0d was not acknowledged at %0t", addr, $time);
    end
  endtask

  // write ack carries no read data
  task automatic bus_write(logic [`BUS_AW-1:0] addr, logic [`BUS_DW-1:0] data);
    logic [`BUS_DW-1:0] rdata;
    bus_cycle(1'b1, addr, data, rdata);
    check_eq(rdata, '0, "read data on write ack");
  endtask

  task automatic bus_read(logic [`BUS_AW-1:0] addr, output logic [`BUS_DW-1:0] data);
    bus_cycle(1'b0, addr, '0, data);
  endtask

  // bus stays quiet while no access is pending
  task automatic wait_cycles(int n);
    repeat (n) begin
      @(negedge adc_clk);
      check_eq(bus_rsp.ack, 1'b0, "ack without strobe");
      check_eq(bus_rsp.rdata, '0, "read data without strobe");
    end
  endtask

  // writes one gain and offset pair and remembers it
  task automatic set_cal(bit is_dac, int ch, logic [15:0] mul, logic [`SMP_W-1:0] sum);
    int a;
    a = (is_dac ? regbus_pkg::ADDR_DAC_MUL0 : regbus_pkg::ADDR_ADC_MUL0) + 2 * ch;
    bus_write(a, {16'h0, mul});
    bus_write(a + 1, {{(`BUS_DW-`SMP_W){sum[`SMP_W-1]}}, sum});
    if (is_dac) begin
      dac_mul[ch] = $signed(mul);
      dac_sum[ch] = $signed(sum);
    end else begin
      adc_mul[ch] = $signed(mul);
      adc_sum[ch] = $signed(sum);
    end
  endtask

  // trigger, then read both scope samples
  task automatic snap_expect(int e0, int e1, string what);
    logic [`BUS_DW-1:0] d;
    bus_write(regbus_pkg::ADDR_SNAP_TRIG, 32'h1);
    bus_read(regbus_pkg::ADDR_SNAP_OSC0, d);
    check_eq(d, e0, {what, " osc0"});
    bus_read(regbus_pkg::ADDR_SNAP_OSC1, d);
    check_eq(d, e1, {what, " osc1"});
  endtask

  task automatic report(string name, int err0);
    tests++;
    if (errors == err0) $display("test %s passed", name);
    else $display("test %s failed with %0d errors", name, errors - err0);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset_defaults();
    int err0;
    logic [`BUS_DW-1:0] d;
    err0 = errors;
    // no clock edge yet since release
    check_eq(dac_dat, '0, "dac code after reset");
    // gains at odd words 1 to 7, all else zero incl. unmapped
    for (int a = 0; a < 16; a++) begin
      bus_read(a, d);
      check_eq(d, (a >= 1 && a <= 8 && a % 2 == 1) ? `CAL_UNITY : 0,
               $sformatf("reset read addr %0d", a));
    end
    report("reset_defaults", err0);
  endtask

  task automatic test_adc_unity();
    int err0;
    err0 = errors;
    for (int k = 0; k < 4; k++) begin
      adc_dat[0] = (k == 0) ? 16'h0000 : $random(seed);
      adc_dat[1] = (k == 0) ? 16'hffff : $random(seed);
      wait_cycles(3);
      snap_expect(adc_model(adc_dat[0]), adc_model(adc_dat[1]), "adc unity");
    end
    report("adc_unity", err0);
  endtask

  task automatic test_adc_cal();
    int err0;
    logic [15:0] mul;
    err0 = errors;
    for (int k = 0; k < 6; k++) begin
      for (int c = 0; c < `ANALOG_CHN; c++) begin
        mul = $random(seed);
        // +4.0, -4.0 and zero gain cases
        if (k == 3) mul = 16'h7fff;
        if (k == 4) mul = 16'h8000;
        if (k == 5) mul = 16'h0000;
        set_cal(0, c, mul, $random(seed));
        adc_dat[c] = $random(seed);
      end
      // full scale inputs of both signs
      if (k == 3 || k == 4) adc_dat = {16'hffff, 16'h0000};
      wait_cycles(3);
      if (k == 3) snap_expect(SMAX, SMIN, "adc clip");
      else if (k == 4) snap_expect(SMIN, SMAX, "adc clip");
      else snap_expect(cal_model(adc_model(adc_dat[0]), adc_mul[0], adc_sum[0]),
                       cal_model(adc_model(adc_dat[1]), adc_mul[1], adc_sum[1]), "adc cal");
    end
    for (int c = 0; c < `ANALOG_CHN; c++) set_cal(0, c, `CAL_UNITY, 0);
    report("adc_cal", err0);
  endtask

  task automatic test_dac_stream();
    int err0;
    int hist [`ANALOG_CHN][40];
    err0 = errors;
    for (int c = 0; c < `ANALOG_CHN; c++) set_cal(1, c, $random(seed) & 16'h3fff, $random(seed));
    // new sample every cycle, output three cycles later
    for (int k = 0; k < 43; k++) begin
      for (int c = 0; c < `ANALOG_CHN; c++) begin
        if (k >= 3)
          check_eq(dac_dat[c], dac_model(cal_model(hist[c][k-3], dac_mul[c], dac_sum[c])),
                   $sformatf("dac ch%0d sample %0d", c, k - 3));
        if (k < 40) begin
          gen_dat[c] = $random(seed);
          hist[c][k] = gen_dat[c];
        end
      end
      @(negedge adc_clk);
    end
    report("dac_stream", err0);
  endtask

  task automatic test_loopback();
    int err0;
    err0 = errors;
    bus_write(regbus_pkg::ADDR_MUX, 32'h3);
    for (int c = 0; c < `ANALOG_CHN; c++) set_cal(0, c, $random(seed) & 16'h3fff, $random(seed));
    for (int k = 0; k < 3; k++) begin
      // adc inputs change too and must not matter
      for (int c = 0; c < `ANALOG_CHN; c++) begin
        gen_dat[c] = $random(seed);
        adc_dat[c] = $random(seed);
      end
      wait_cycles(4);
      snap_expect(cal_model(cal_model(gen_dat[0], dac_mul[0], dac_sum[0]), adc_mul[0], adc_sum[0]),
                  cal_model(cal_model(gen_dat[1], dac_mul[1], dac_sum[1]), adc_mul[1], adc_sum[1]),
                  "loopback");
    end
    bus_write(regbus_pkg::ADDR_MUX, 32'h0);
    report("loopback", err0);
  endtask

  task automatic test_timestamp();
    int err0;
    logic [`BUS_DW-1:0] lo;
    logic [`BUS_DW-1:0] hi;
    logic [`CTS_W-1:0] t0;
    logic [`CTS_W-1:0] diff;
    err0 = errors;
    bus_write(regbus_pkg::ADDR_SNAP_TRIG, 32'h1);
    bus_read(regbus_pkg::ADDR_CTS_LO, lo);
    bus_read(regbus_pkg::ADDR_CTS_HI, hi);
    t0 = {hi, lo};
    // three cycles already spent since the first trigger
    wait_cycles(GAP - 3);
    bus_write(regbus_pkg::ADDR_SNAP_TRIG, 32'h1);
    bus_read(regbus_pkg::ADDR_CTS_LO, lo);
    bus_read(regbus_pkg::ADDR_CTS_HI, hi);
    diff = {hi, lo} - t0;
    check_eq(diff[31:0], GAP, "timestamp difference low");
    check_eq(diff[63:32], 0, "timestamp difference high");
    report("timestamp", err0);
  endtask

  initial begin
    top_rst = 1'b1;
    adc_dat = '0;
    bus_req = '0;
    for (int c = 0; c < `ANALOG_CHN; c++) gen_dat[c] = '0;
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    top_rst = 1'b0;
    test_reset_defaults();
    test_adc_unity();
    test_adc_cal();
    test_dac_stream();
    test_loopback();
    test_timestamp();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* analog_top.f */
+incdir+include
design/analog_pkg.sv
design/regbus_pkg.sv
design/reg_decode.sv
design/cal_linear.sv
design/channel_path.sv
design/scope_snapshot.sv
design/analog_top.sv
verification/analog_top_tb.sv
